/* design/baser_257b_pkg.sv */
package baser_257b_pkg;

    // Lane and block geometry
    localparam int DATA_WIDTH  = 64;
    localparam int NUM_LANES   = 4;
    localparam int XCODE_WIDTH = NUM_LANES * DATA_WIDTH + 1;
    localparam int BODY_WIDTH  = DATA_WIDTH - 8;
    localparam int CHAR_WIDTH  = 7;

    typedef logic [XCODE_WIDTH-1:0] xcode_t;
    typedef logic [DATA_WIDTH-1:0]  lane_data_t;
    typedef logic [BODY_WIDTH-1:0]  ctrl_body_t;
    typedef logic [7:0]             blk_type_t;
    typedef logic [31:0]            stat_count_t;

    // Fixed test patterns
    localparam logic [7:0]            DATA_CHAR = 8'hAA;
    localparam logic [CHAR_WIDTH-1:0] CTRL_CHAR = 7'h1E;
    localparam logic [3:0]            OSET_CODE = 4'hF;

    // 64b/66b control block type bytes
    localparam blk_type_t TYPE_CTRL   = 8'h1E;
    localparam blk_type_t TYPE_START  = 8'h78;
    localparam blk_type_t TYPE_OSET   = 8'h4B;
    localparam blk_type_t TYPE_TERM_0 = 8'h87;
    localparam blk_type_t TYPE_TERM_1 = 8'h99;
    localparam blk_type_t TYPE_TERM_2 = 8'hAA;
    localparam blk_type_t TYPE_TERM_3 = 8'hB4;
    localparam blk_type_t TYPE_TERM_4 = 8'hCC;
    localparam blk_type_t TYPE_TERM_5 = 8'hD2;
    localparam blk_type_t TYPE_TERM_6 = 8'hE1;
    localparam blk_type_t TYPE_TERM_7 = 8'hFF;

    // The first control lane of a 257b block carries only the high nibble
    // of its type byte; every valid type has a distinct high nibble
    function automatic blk_type_t type_from_nibble(input logic [3:0] nibble);
        blk_type_t type_byte;
        case (nibble)
            4'h1:    type_byte = TYPE_CTRL;
            4'h7:    type_byte = TYPE_START;
            4'h4:    type_byte = TYPE_OSET;
            4'h8:    type_byte = TYPE_TERM_0;
            4'h9:    type_byte = TYPE_TERM_1;
            4'hA:    type_byte = TYPE_TERM_2;
            4'hB:    type_byte = TYPE_TERM_3;
            4'hC:    type_byte = TYPE_TERM_4;
            4'hD:    type_byte = TYPE_TERM_5;
            4'hE:    type_byte = TYPE_TERM_6;
            4'hF:    type_byte = TYPE_TERM_7;
            // Matches no type rule downstream
            default: type_byte = 8'h00;
        endcase
        return type_byte;
    endfunction

endpackage

/* design/xcode_lane_splitter.sv */
`timescale 1ns/1ps

module xcode_lane_splitter
    import baser_257b_pkg::*;
(
    input  xcode_t                  i_xcoded,
    output logic [NUM_LANES-1:0]    o_is_ctrl,
    output blk_type_t               o_lane_type [NUM_LANES],
    output ctrl_body_t              o_lane_body [NUM_LANES],
    output lane_data_t              o_lane_data [NUM_LANES],
    output logic                    o_all_data,
    output logic                    o_layout_bad
);

    // Zero tail so a data lane 3 ahead of any control lane can still be
    // sliced at its +4 offset; that layout is flagged bad anyway
    logic [XCODE_WIDTH+3:0] xcoded_ext;
    logic [NUM_LANES-1:0]   lane_flags;

    assign xcoded_ext = {4'b0000, i_xcoded};

    // Flag bit set means data lane, clear means control lane
    assign lane_flags = i_xcoded[NUM_LANES:1];
    assign o_all_data = i_xcoded[0];

    // Header 0 must carry at least one control lane
    assign o_layout_bad = !i_xcoded[0] && (&lane_flags);

    always_comb begin
        logic ctrl_seen;
        int   base;

        ctrl_seen = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            base = 1 + DATA_WIDTH * i;

            // Layout once a control lane has been seen, also the all-data layout
            o_is_ctrl[i]   = 1'b0;
            o_lane_type[i] = '0;
            o_lane_body[i] = xcoded_ext[base + $bits(blk_type_t) +: BODY_WIDTH];
            o_lane_data[i] = xcoded_ext[base +: DATA_WIDTH];

            if (!o_all_data) begin
                if (lane_flags[i]) begin
                    // Data lanes ahead of the first control lane sit behind the flags
                    if (!ctrl_seen) begin
                        o_lane_data[i] = xcoded_ext[base + 4 +: DATA_WIDTH];
                    end
                end else if (!ctrl_seen) begin
                    // First control lane, compressed type nibble
                    ctrl_seen      = 1'b1;
                    o_is_ctrl[i]   = 1'b1;
                    o_lane_type[i] = type_from_nibble(xcoded_ext[base + 4 +: 4]);
                end else begin
                    // Later control lanes keep their full type byte
                    o_is_ctrl[i]   = 1'b1;
                    o_lane_type[i] = xcoded_ext[base +: $bits(blk_type_t)];
                end
            end
        end
    end

endmodule

/* design/lane_format_checker.sv */
`timescale 1ns/1ps

module lane_format_checker
    import baser_257b_pkg::*;
(
    input  logic        i_is_ctrl,
    input  blk_type_t   i_type,
    input  ctrl_body_t  i_body,
    input  lane_data_t  i_data,
    output logic        o_lane_bad
);

    // Body of a terminate in character n, from bit 0 upward:
    // n data chars, 7-n zero bits, then 7-n control chars
    function automatic ctrl_body_t term_body(input int unsigned n);
        ctrl_body_t  body;
        int unsigned ctrl_base;

        body      = '0;
        ctrl_base = 8 * n + (7 - n);
        for (int unsigned b = 0; b < 7; b++) begin
            if (b < n) begin
                body[8*b +: 8] = DATA_CHAR;
            end
        end
        for (int unsigned c = 0; c < 7; c++) begin
            if (c < 7 - n) begin
                body[ctrl_base + CHAR_WIDTH*c +: CHAR_WIDTH] = CTRL_CHAR;
            end
        end
        return body;
    endfunction

    logic       data_ok;
    logic       type_known;
    ctrl_body_t body_exp;

    // Data lane is eight data characters
    assign data_ok = (i_data == {(DATA_WIDTH/8){DATA_CHAR}});

    // Expected control body for the lane's type
    always_comb begin
        type_known = 1'b1;
        body_exp   = '0;
        case (i_type)
            // C0..C7
            TYPE_CTRL: begin
                body_exp = {8{CTRL_CHAR}};
            end
            // S0 D1..D7
            TYPE_START: begin
                body_exp = {7{DATA_CHAR}};
            end
            // O0 D1..D3 Z4..Z7
            TYPE_OSET: begin
                body_exp = {28'd0, OSET_CODE, {3{DATA_CHAR}}};
            end
            TYPE_TERM_0: begin
                body_exp = term_body(0);
            end
            TYPE_TERM_1: begin
                body_exp = term_body(1);
            end
            TYPE_TERM_2: begin
                body_exp = term_body(2);
            end
            TYPE_TERM_3: begin
                body_exp = term_body(3);
            end
            TYPE_TERM_4: begin
                body_exp = term_body(4);
            end
            TYPE_TERM_5: begin
                body_exp = term_body(5);
            end
            TYPE_TERM_6: begin
                body_exp = term_body(6);
            end
            TYPE_TERM_7: begin
                body_exp = term_body(7);
            end
            default: begin
                type_known = 1'b0;
            end
        endcase
    end

    assign o_lane_bad = i_is_ctrl ? !(type_known && (i_body == body_exp)) : !data_ok;

endmodule

/* design/block_stat_counters.sv */
`timescale 1ns/1ps

module block_stat_counters
    import baser_257b_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  logic                    i_all_data,
    input  logic                    i_layout_bad,
    input  logic [NUM_LANES-1:0]    i_lane_bad,
    output stat_count_t             o_block_count,
    output stat_count_t             o_data_count,
    output stat_count_t             o_ctrl_count,
    output stat_count_t             o_inv_block_count,
    output logic                    o_blk_err
);

    logic blk_bad;

    // One bad lane or a bad layout spoils the whole block
    assign blk_bad = i_layout_bad || (|i_lane_bad);

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_block_count     <= '0;
            o_data_count      <= '0;
            o_ctrl_count      <= '0;
            o_inv_block_count <= '0;
            o_blk_err         <= 1'b0;
        end else begin
            // Pulse only for the cycle after a bad block
            o_blk_err <= i_valid && blk_bad;

            if (i_valid) begin
                o_block_count <= o_block_count + 32'd1;

                if (i_all_data) begin
                    o_data_count <= o_data_count + 32'd1;
                end else begin
                    o_ctrl_count <= o_ctrl_count + 32'd1;
                end

                if (blk_bad) begin
                    o_inv_block_count <= o_inv_block_count + 32'd1;
                end
            end
        end
    end

endmodule

/* design/baser_257b_checker.sv */
`timescale 1ns/1ps

module baser_257b_checker
    import baser_257b_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_valid,
    input  xcode_t      i_xcoded,
    output stat_count_t o_block_count,
    output stat_count_t o_data_count,
    output stat_count_t o_ctrl_count,
    output stat_count_t o_inv_block_count,
    output logic        o_blk_err
);

    // Per-lane views from the splitter
    logic [NUM_LANES-1:0] lane_is_ctrl;
    blk_type_t            lane_type [NUM_LANES];
    ctrl_body_t           lane_body [NUM_LANES];
    lane_data_t           lane_data [NUM_LANES];
    logic [NUM_LANES-1:0] lane_bad;
    logic                 all_data;
    logic                 layout_bad;

    xcode_lane_splitter u_splitter (
        .i_xcoded     (i_xcoded),
        .o_is_ctrl    (lane_is_ctrl),
        .o_lane_type  (lane_type),
        .o_lane_body  (lane_body),
        .o_lane_data  (lane_data),
        .o_all_data   (all_data),
        .o_layout_bad (layout_bad)
    );

    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
            lane_format_checker u_lane_chk (
                .i_is_ctrl  (lane_is_ctrl[i]),
                .i_type     (lane_type[i]),
                .i_body     (lane_body[i]),
                .i_data     (lane_data[i]),
                .o_lane_bad (lane_bad[i])
            );
        end
    endgenerate

    block_stat_counters u_counters (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_valid           (i_valid),
        .i_all_data        (all_data),
        .i_layout_bad      (layout_bad),
        .i_lane_bad        (lane_bad),
        .o_block_count     (o_block_count),
        .o_data_count      (o_data_count),
        .o_ctrl_count      (o_ctrl_count),
        .o_inv_block_count (o_inv_block_count),
        .o_blk_err         (o_blk_err)
    );

endmodule

/* include/tb_block_table.svh */
`ifndef TB_BLOCK_TABLE_SVH
`define TB_BLOCK_TABLE_SVH

// Corruption applied to the lane named in the descriptor
localparam logic [2:0] CORR_NONE = 3'd0;
localparam logic [2:0] CORR_DATA = 3'd1;    // flip a data byte
localparam logic [2:0] CORR_ZERO = 3'd2;    // set a bit of a zero field
localparam logic [2:0] CORR_OSET = 3'd3;    // wrong ordered-set code
localparam logic [2:0] CORR_TYPE = 3'd4;    // unknown type byte or nibble

// Lane i uses flags[i] and types[i]; flag 1 is a data lane
typedef struct packed {
    logic             hdr;
    logic [3:0]       flags;
    logic [3:0][7:0]  types;
    logic [2:0]       corr;
    logic [1:0]       corr_lane;
    logic             exp_err;
} tb_blk_desc_t;

localparam int TB_NUM_BLOCKS = 31;

localparam tb_blk_desc_t TB_BLOCKS [TB_NUM_BLOCKS] = '{
    // All-data blocks
    '{1'b1, 4'b1111, '0, CORR_NONE, 2'd0, 1'b0},
    '{1'b1, 4'b1111, '0, CORR_DATA, 2'd2, 1'b1},
    // Type under test as the first control lane, lane 1
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_CTRL,   8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_START,  8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_OSET,   8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_0, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_1, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_2, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_3, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_4, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_5, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_6, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_7, 8'h00}, CORR_NONE, 2'd0, 1'b0},
    // Type under test as a later control lane, lane 3
    '{1'b0, 4'b0110, {TYPE_CTRL,   8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_START,  8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_OSET,   8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_0, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_1, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_2, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_3, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_4, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_5, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_6, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    '{1'b0, 4'b0110, {TYPE_TERM_7, 8'h00, 8'h00, TYPE_CTRL}, CORR_NONE, 2'd0, 1'b0},
    // Malformed control blocks
    '{1'b0, 4'b0110, {TYPE_CTRL,   8'h00, 8'h00, TYPE_CTRL}, CORR_TYPE, 2'd3, 1'b1},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_START,  8'h00},     CORR_TYPE, 2'd1, 1'b1},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_TERM_2, 8'h00},     CORR_ZERO, 2'd1, 1'b1},
    '{1'b0, 4'b0110, {TYPE_OSET,   8'h00, 8'h00, TYPE_CTRL}, CORR_ZERO, 2'd3, 1'b1},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_OSET,   8'h00},     CORR_OSET, 2'd1, 1'b1},
    '{1'b0, 4'b1101, {8'h00, 8'h00, TYPE_CTRL,   8'h00},     CORR_DATA, 2'd3, 1'b1},
    '{1'b0, 4'b1111, '0,                                     CORR_NONE, 2'd0, 1'b1}
};

`endif

/* tests/tb_baser_257b_checker.sv */
`timescale 1ns/1ps

module tb_baser_257b_checker
    import baser_257b_pkg::*;
();

    localparam int WAIT_LIMIT = 8;
    localparam int NUM_RANDOM = 24;

    logic        clk      = 1'b0;
    logic        i_rst    = 1'b1;
    logic        i_valid  = 1'b0;
    xcode_t      i_xcoded = '0;
    stat_count_t o_block_count;
    stat_count_t o_data_count;
    stat_count_t o_ctrl_count;
    stat_count_t o_inv_block_count;
    logic        o_blk_err;

    int          errors;
    int          tests;
    integer      seed;
    stat_count_t exp_blocks;
    stat_count_t exp_data;
    stat_count_t exp_ctrl;
    stat_count_t exp_inv;

    `include "tb_block_table.svh"

    // Terminate types sit at index 3 + n
    localparam blk_type_t VALID_TYPES [11] = '{
        TYPE_CTRL, TYPE_START, TYPE_OSET,
        TYPE_TERM_0, TYPE_TERM_1, TYPE_TERM_2, TYPE_TERM_3,
        TYPE_TERM_4, TYPE_TERM_5, TYPE_TERM_6, TYPE_TERM_7
    };

    always #20 clk = ~clk;

    baser_257b_checker DUT (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_valid           (i_valid),
        .i_xcoded          (i_xcoded),
        .o_block_count     (o_block_count),
        .o_data_count      (o_data_count),
        .o_ctrl_count      (o_ctrl_count),
        .o_inv_block_count (o_inv_block_count),
        .o_blk_err         (o_blk_err)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            errors++;
            $display("ERR %s exp=%h got=%h", name, exp, got);
        end
    endtask

    task automatic check_outputs(input logic exp_err);
        check_value("o_block_count", exp_blocks, o_block_count);
        check_value("o_data_count", exp_data, o_data_count);
        check_value("o_ctrl_count", exp_ctrl, o_ctrl_count);
        check_value("o_inv_block_count", exp_inv, o_inv_block_count);
        check_value("o_blk_err", 32'(exp_err), 32'(o_blk_err));
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED", name);
        end
    endtask

    // Control body from bit 0 upward with a mask of its zero-fill bits
    function automatic ctrl_body_t body_for_type(input blk_type_t t, output ctrl_body_t zmask);
        ctrl_body_t body;
        int         n;

        body  = '0;
        zmask = '0;
        n     = -1;
        for (int k = 0; k < 8; k++) begin
            if (t == VALID_TYPES[3 + k]) begin
                n = k;
            end
        end
        if (t == TYPE_CTRL) begin
            for (int c = 0; c < 8; c++) begin
                body[CHAR_WIDTH*c +: CHAR_WIDTH] = CTRL_CHAR;
            end
        end else if (t == TYPE_START) begin
            for (int b = 0; b < 7; b++) begin
                body[8*b +: 8] = DATA_CHAR;
            end
        end else if (t == TYPE_OSET) begin
            for (int b = 0; b < 3; b++) begin
                body[8*b +: 8] = DATA_CHAR;
            end
            body[27:24]             = OSET_CODE;
            zmask[BODY_WIDTH-1:28] = '1;
        end else if (n >= 0) begin
            for (int b = 0; b < n; b++) begin
                body[8*b +: 8] = DATA_CHAR;
            end
            for (int z = 0; z < 7 - n; z++) begin
                zmask[8*n + z] = 1'b1;
            end
            for (int c = 0; c < 7 - n; c++) begin
                body[8*n + (7 - n) + CHAR_WIDTH*c +: CHAR_WIDTH] = CTRL_CHAR;
            end
        end
        return body;
    endfunction

    // Assemble a 257-bit block from a descriptor, corruption included
    function automatic xcode_t build_block(input tb_blk_desc_t d);
        logic [XCODE_WIDTH+3:0] blk;
        lane_data_t             payload [NUM_LANES];
        blk_type_t              tbyte [NUM_LANES];
        ctrl_body_t             body [NUM_LANES];
        ctrl_body_t             zmask;
        logic                   ctrl_seen;
        int                     base;
        int                     bit_pos;

        for (int i = 0; i < NUM_LANES; i++) begin
            payload[i] = {8{DATA_CHAR}};
            tbyte[i]   = d.types[i];
            body[i]    = body_for_type(d.types[i], zmask);
            if (i == int'(d.corr_lane)) begin
                if (d.corr == CORR_DATA) begin
                    payload[i][15:8] = ~DATA_CHAR;
                end else if (d.corr == CORR_ZERO) begin
                    // Lowest bit of the zero field
                    bit_pos = -1;
                    for (int b = BODY_WIDTH - 1; b >= 0; b--) begin
                        if (zmask[b]) begin
                            bit_pos = b;
                        end
                    end
                    if (bit_pos >= 0) begin
                        body[i][bit_pos] = 1'b1;
                    end
                end else if (d.corr == CORR_OSET) begin
                    body[i][27:24] = ~OSET_CODE;
                end else if (d.corr == CORR_TYPE) begin
                    // Neither 0x2D nor its nibble 0x2 is a known type
                    tbyte[i] = 8'h2D;
                end
            end
        end

        blk       = '0;
        blk[0]    = d.hdr;
        ctrl_seen = 1'b0;
        if (d.hdr) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                blk[1 + DATA_WIDTH*i +: DATA_WIDTH] = payload[i];
            end
        end else begin
            blk[NUM_LANES:1] = d.flags;
            for (int i = 0; i < NUM_LANES; i++) begin
                base = 1 + DATA_WIDTH * i;
                if (d.flags[i]) begin
                    if (ctrl_seen) begin
                        blk[base +: DATA_WIDTH] = payload[i];
                    end else begin
                        blk[base + 4 +: DATA_WIDTH] = payload[i];
                    end
                end else begin
                    if (ctrl_seen) begin
                        blk[base +: 8] = tbyte[i];
                    end else begin
                        blk[base + 4 +: 4] = tbyte[i][7:4];
                    end
                    blk[base + 8 +: BODY_WIDTH] = body[i];
                    ctrl_seen = 1'b1;
                end
            end
        end
        return blk[XCODE_WIDTH-1:0];
    endfunction

    // Present one block and wait for the block count to advance
    task automatic apply_block(input string name, input xcode_t blk,
                               input logic hdr, input logic exp_err);
        int          errs_before;
        int          cycles;
        stat_count_t prev_count;

        errs_before = errors;
        prev_count  = o_block_count;
        i_valid     = 1'b1;
        i_xcoded    = blk;
        cycles      = 0;
        while (o_block_count == prev_count && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            i_valid = 1'b0;
            cycles++;
        end
        if (o_block_count == prev_count) begin
            errors++;
            $display("%s: block count never advanced after the block was applied", name);
        end else if (cycles != 1) begin
            errors++;
            $display("%s: block was counted after %0d cycles instead of 1", name, cycles);
        end
        exp_blocks = exp_blocks + 32'd1;
        if (hdr) begin
            exp_data = exp_data + 32'd1;
        end else begin
            exp_ctrl = exp_ctrl + 32'd1;
        end
        if (exp_err) begin
            exp_inv = exp_inv + 32'd1;
        end
        check_outputs(exp_err);
        report_test(name, errs_before);
    endtask

    task automatic idle_cycles(input string name, input int n);
        int errs_before;

        errs_before = errors;
        i_valid     = 1'b0;
        for (int c = 0; c < n; c++) begin
            @(posedge clk);
            #2;
            check_outputs(1'b0);
        end
        report_test(name, errs_before);
    endtask

    initial begin
        tb_blk_desc_t d;
        xcode_t       blk;
        logic [31:0]  rnd;
        int           pick;
        int           errs_before;

        errors     = 0;
        tests      = 0;
        exp_blocks = '0;
        exp_data   = '0;
        exp_ctrl   = '0;
        exp_inv    = '0;
        seed       = 32'h9a8e_d8c4;

        repeat (3) @(posedge clk);
        #2;
        i_rst = 1'b0;
        errs_before = errors;
        check_outputs(1'b0);
        report_test("reset state", errs_before);

        for (int t = 0; t < TB_NUM_BLOCKS; t++) begin
            d = TB_BLOCKS[t];
            apply_block($sformatf("table %0d", t), build_block(d), d.hdr, d.exp_err);
            if (t % 4 == 3) begin
                idle_cycles($sformatf("idle after table %0d", t), 2);
            end
        end

        // Random all-data blocks with an optional bit flip and random valid control blocks
        for (int r = 0; r < NUM_RANDOM; r++) begin
            rnd   = $random(seed);
            d     = '0;
            d.hdr = rnd[0];
            if (!d.hdr) begin
                d.flags = rnd[5:2];
                if (d.flags == 4'b1111) begin
                    d.flags = 4'b1110;
                end
                for (int i = 0; i < NUM_LANES; i++) begin
                    pick       = int'($unsigned($random(seed)) % 11);
                    d.types[i] = VALID_TYPES[pick];
                end
            end
            blk = build_block(d);
            if (d.hdr && rnd[1]) begin
                pick      = 1 + int'($unsigned($random(seed)) % 256);
                blk[pick] = ~blk[pick];
            end
            apply_block($sformatf("random %0d", r), blk, d.hdr, d.hdr && rnd[1]);
        end

        idle_cycles("final idle", 1);
        errs_before = errors;
        check_outputs(1'b0);
        check_value("o_block_count", TB_NUM_BLOCKS + NUM_RANDOM, o_block_count);
        report_test("final tallies", errs_before);

        $display("tests=%0d errors=%0d blocks=%0d invalid=%0d",
                 tests, errors, exp_blocks, exp_inv);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
design/baser_257b_pkg.sv
design/xcode_lane_splitter.sv
design/lane_format_checker.sv
design/block_stat_counters.sv
design/baser_257b_checker.sv
tests/tb_baser_257b_checker.sv

/* Makefile */
# Verilator build and run for the 257b block checker

VERILATOR ?= verilator
TOP       ?= tb_baser_257b_checker
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation did not complete, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
